// File: common/video_pkg.sv
// ==================================================
// video_pkg
// frame geometry of the shrunk simulation frame and
// the pixel structs passed from the layers to the
// colour mixer
// ==================================================
package video_pkg;

    // geometry, horizontal in pixel enables, vertical in lines
    localparam int h_total   = 64;  // pixel enables per line
    localparam int h_visible = 48;
    localparam int v_total   = 32;  // lines per frame
    localparam int v_visible = 24;
    localparam int pxl_div   = 2;   // clocks per pixel enable

    // counter widths
    localparam int h_cnt_w = $clog2(h_total);
    localparam int v_cnt_w = $clog2(v_total);
    localparam int div_w   = $clog2(pxl_div);

    // layer codes of one pixel as the tilemap and sprite engines deliver them
    typedef struct packed {
        logic [4:0] bak_code;   // background colour code
        logic [5:0] obj_code;   // object colour code
        logic [1:0] obj_valid;  // object pixel value, zero when transparent
        logic [3:0] txt_code;   // text colour code
        logic       txt_valid;  // active low, low selects text
    } layer_pix_t;

    // 3-3-2 output pixel
    // blue sits in palette bits 7..6, red in 2..0
    typedef struct packed {
        logic [1:0] blue;
        logic [2:0] green;
        logic [2:0] red;
    } rgb_t;

endpackage

// File: common/palette_pkg.sv
// ==================================================
// palette_pkg
// colour PROM sizes and the address map of the
// PROM download stream
// ==================================================
package palette_pkg;

    localparam int prog_aw = 10;    // download address width
    localparam int bak_aw  = 5;     // background and text proms
    localparam int obj_aw  = 8;     // object proms, widest local address

    // region bases in the download space
    localparam int rgn_bak_base   = 0;
    localparam int rgn_txt_base   = 32;
    localparam int rgn_objlo_base = 256;   // low nibble of object colour
    localparam int rgn_objhi_base = 512;   // high nibble of object colour

    // which prom a download byte goes to
    typedef enum logic [2:0] {
        rgn_none,       // gap in the map, byte dropped
        rgn_bak,
        rgn_txt,
        rgn_objlo,
        rgn_objhi
    } prom_rgn_e;

endpackage

// File: hw/video_timing.sv
// ==================================================
// video_timing
// pixel clock enable from the system clock, line and
// frame counters, and the blanking levels
// ==================================================
`timescale 1ns/1ns

module video_timing (
    input  logic clk,
    input  logic arst_n,
    output logic pxl_cen,     // one clock every pxl_div clocks
    output logic hblank_n,
    output logic vblank_n
);
    import video_pkg::*;

    logic [div_w-1:0]   div_cnt;
    logic [h_cnt_w-1:0] hcnt;
    logic [v_cnt_w-1:0] vcnt;
    logic [h_cnt_w-1:0] hcnt_nx;
    logic [v_cnt_w-1:0] vcnt_nx;
    logic               line_end;

    // next counter values, only taken on pxl_cen
    always_comb begin
        line_end = hcnt == h_cnt_w'(h_total - 1);
        hcnt_nx  = line_end ? '0 : hcnt + 1'b1;
        vcnt_nx  = vcnt;
        if (line_end) begin
            vcnt_nx = (vcnt == v_cnt_w'(v_total - 1)) ? '0 : vcnt + 1'b1;
        end
    end

    // clock divider
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            pxl_cen <= 1'b0;
        end else begin
            div_cnt <= (div_cnt == div_w'(pxl_div - 1)) ? '0 : div_cnt + 1'b1;
            pxl_cen <= div_cnt == div_w'(pxl_div - 1);  // registered pulse
        end
    end

    // counters and blanking move together so the levels always match the counts
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hcnt     <= '0;
            vcnt     <= '0;
            hblank_n <= 1'b1;   // count 0 is visible
            vblank_n <= 1'b1;
        end else if (pxl_cen) begin
            hcnt     <= hcnt_nx;
            vcnt     <= vcnt_nx;
            hblank_n <= int'(hcnt_nx) < h_visible;
            vblank_n <= int'(vcnt_nx) < v_visible;
        end
    end

endmodule

// File: hw/prom_loader.sv
// ==================================================
// prom_loader
// splits the byte download stream over the four
// colour PROMs, with region-local address and a
// write strobe one clock after the download write
// ==================================================
`timescale 1ns/1ns

module prom_loader (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [palette_pkg::prog_aw-1:0] prog_addr,
    input  logic [7:0]                      prog_data,
    input  logic                            prog_we,    // one clock strobe
    output logic                            bak_we,
    output logic                            txt_we,
    output logic                            objlo_we,
    output logic                            objhi_we,
    output logic [palette_pkg::obj_aw-1:0]  prom_addr,  // local to the region
    output logic [7:0]                      prom_data
);
    import palette_pkg::*;

    prom_rgn_e          rgn;
    logic [prog_aw-1:0] rgn_base;
    logic [prog_aw-1:0] loc_addr;

    // addr inside the 2**aw bytes from base
    function automatic logic in_rgn(
        input logic [prog_aw-1:0] addr,
        input int                 base,
        input int                 aw
    );
        return int'(addr) >= base && int'(addr) < base + (1 << aw);
    endfunction

    // address decode
    always_comb begin
        rgn      = rgn_none;
        rgn_base = '0;
        if (in_rgn(prog_addr, rgn_bak_base, bak_aw)) begin
            rgn      = rgn_bak;
            rgn_base = prog_aw'(rgn_bak_base);
        end else if (in_rgn(prog_addr, rgn_txt_base, bak_aw)) begin
            rgn      = rgn_txt;     // text prom is as deep as background
            rgn_base = prog_aw'(rgn_txt_base);
        end else if (in_rgn(prog_addr, rgn_objlo_base, obj_aw)) begin
            rgn      = rgn_objlo;
            rgn_base = prog_aw'(rgn_objlo_base);
        end else if (in_rgn(prog_addr, rgn_objhi_base, obj_aw)) begin
            rgn      = rgn_objhi;
            rgn_base = prog_aw'(rgn_objhi_base);
        end
        loc_addr = prog_addr - rgn_base;
    end

    // at most one strobe, none for rgn_none
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bak_we   <= 1'b0;
            txt_we   <= 1'b0;
            objlo_we <= 1'b0;
            objhi_we <= 1'b0;
        end else begin
            bak_we   <= prog_we && rgn == rgn_bak;
            txt_we   <= prog_we && rgn == rgn_txt;
            objlo_we <= prog_we && rgn == rgn_objlo;
            objhi_we <= prog_we && rgn == rgn_objhi;
        end
    end

    always_ff @(posedge clk) begin
        prom_addr <= loc_addr[obj_aw-1:0];  // upper bits are zero after the subtract
        prom_data <= prog_data;
    end

endmodule

// File: hw/colmix/palette_prom.sv
// ==================================================
// palette_prom
// writable colour lookup table, read port
// registered on the pixel enable
// ==================================================
`timescale 1ns/1ns

module palette_prom #(
    parameter int aw = 5,
    parameter int dw = 8
) (
    input  logic          clk,
    input  logic          cen,      // pixel enable
    input  logic [aw-1:0] wr_addr,
    input  logic [dw-1:0] wr_data,
    input  logic          we,
    input  logic [aw-1:0] rd_addr,
    output logic [dw-1:0] q
);

    logic [dw-1:0] mem [2**aw];    // filled only by the download

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
        if (cen) begin
            q <= mem[rd_addr];      // holds between pixel enables
        end
    end

endmodule

// File: hw/colmix/colmix.sv
// ==================================================
// colmix
// fixed layer priority text, object, background,
// palette lookup of the winner, inversion and
// blanking to 3-3-2 RGB, one pixel enable latency
// ==================================================
`timescale 1ns/1ns

module colmix (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           pxl_cen,
    input  logic                           hblank_n,
    input  logic                           vblank_n,
    input  video_pkg::layer_pix_t          pix,
    // download side
    input  logic [palette_pkg::obj_aw-1:0] prom_addr,
    input  logic [7:0]                     prom_data,
    input  logic                           bak_we,
    input  logic                           txt_we,
    input  logic                           objlo_we,
    input  logic                           objhi_we,
    output video_pkg::rgb_t                rgb
);
    import video_pkg::*;
    import palette_pkg::*;

    logic [7:0]        bak_col;
    logic [7:0]        txt_col;
    logic [7:0]        obj_col;     // high nibble from objhi prom
    logic [7:0]        col_sel;
    logic [obj_aw-1:0] obj_rd_addr;
    logic [bak_aw-1:0] txt_rd_addr;
    logic              txt_sel;
    logic              obj_sel;
    logic              blank_q;     // either blanking level low at sample time

    assign obj_rd_addr = {pix.obj_code, pix.obj_valid};
    assign txt_rd_addr = {pix.txt_code[3], pix.txt_code};  // msb repeated

    // sample stage, same enable as the prom reads
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            txt_sel <= 1'b0;
            obj_sel <= 1'b0;
            blank_q <= 1'b1;
        end else if (pxl_cen) begin
            txt_sel <= !pix.txt_valid;
            obj_sel <= |pix.obj_valid;  // text still wins below
            blank_q <= !hblank_n || !vblank_n;
        end
    end

    // priority mux
    always_comb begin
        if (txt_sel) begin
            col_sel = txt_col;
        end else if (obj_sel) begin
            col_sel = obj_col;
        end else begin
            col_sel = bak_col;
        end
    end

    // output stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rgb <= rgb_t'(8'h00);
        end else if (pxl_cen) begin
            rgb <= blank_q ? rgb_t'(8'h00) : rgb_t'(~col_sel);  // proms hold inverted colour
        end
    end

    // background
    palette_prom #(.aw(bak_aw), .dw(8)) bak_prom_i (
        .clk     (clk),
        .cen     (pxl_cen),
        .wr_addr (prom_addr[bak_aw-1:0]),
        .wr_data (prom_data),
        .we      (bak_we),
        .rd_addr (pix.bak_code),
        .q       (bak_col)
    );

    // text
    palette_prom #(.aw(bak_aw), .dw(8)) txt_prom_i (
        .clk     (clk),
        .cen     (pxl_cen),
        .wr_addr (prom_addr[bak_aw-1:0]),
        .wr_data (prom_data),
        .we      (txt_we),
        .rd_addr (txt_rd_addr),
        .q       (txt_col)
    );

    // object, both nibbles come in the low half of the download byte
    palette_prom #(.aw(obj_aw), .dw(4)) objlo_prom_i (
        .clk     (clk),
        .cen     (pxl_cen),
        .wr_addr (prom_addr),
        .wr_data (prom_data[3:0]),
        .we      (objlo_we),
        .rd_addr (obj_rd_addr),
        .q       (obj_col[3:0])
    );

    palette_prom #(.aw(obj_aw), .dw(4)) objhi_prom_i (
        .clk     (clk),
        .cen     (pxl_cen),
        .wr_addr (prom_addr),
        .wr_data (prom_data[3:0]),
        .we      (objhi_we),
        .rd_addr (obj_rd_addr),
        .q       (obj_col[7:4])     // lands in colour bits 7..4
    );

endmodule

// File: hw/video_top.sv
// ==================================================
// video_top
// video timing, colour PROM loader and colour mixer
// of the arcade video board
// ==================================================
`timescale 1ns/1ns

module video_top (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [palette_pkg::prog_aw-1:0] prog_addr,
    input  logic [7:0]                      prog_data,
    input  logic                            prog_we,
    input  video_pkg::layer_pix_t           pix,        // from the layer engines
    output logic                            pxl_cen,
    output logic                            hblank_n,
    output logic                            vblank_n,
    output video_pkg::rgb_t                 rgb
);
    import palette_pkg::*;

    logic [obj_aw-1:0] prom_addr;
    logic [7:0]        prom_data;
    logic              bak_we;
    logic              txt_we;
    logic              objlo_we;
    logic              objhi_we;

    video_timing timing_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .pxl_cen  (pxl_cen),
        .hblank_n (hblank_n),
        .vblank_n (vblank_n)
    );

    prom_loader loader_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_we   (prog_we),
        .bak_we    (bak_we),
        .txt_we    (txt_we),
        .objlo_we  (objlo_we),
        .objhi_we  (objhi_we),
        .prom_addr (prom_addr),
        .prom_data (prom_data)
    );

    colmix colmix_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .pxl_cen   (pxl_cen),
        .hblank_n  (hblank_n),
        .vblank_n  (vblank_n),
        .pix       (pix),
        .prom_addr (prom_addr),
        .prom_data (prom_data),
        .bak_we    (bak_we),
        .txt_we    (txt_we),
        .objlo_we  (objlo_we),
        .objhi_we  (objhi_we),
        .rgb       (rgb)
    );

endmodule

// File: tb/colmix_checker.sv
// ==================================================
// colmix_checker
// shadow copies of the colour tables from the
// download bus, reference model of timing, priority
// and palette, and comparison of the rgb output
// ==================================================
`timescale 1ns/1ns

module colmix_checker (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            check_en,   // tables loaded, compare rgb
    input  logic [palette_pkg::prog_aw-1:0] prog_addr,
    input  logic [7:0]                      prog_data,
    input  logic                            prog_we,
    input  video_pkg::layer_pix_t           pix,
    input  logic                            pxl_cen,
    input  logic                            hblank_n,
    input  logic                            vblank_n,
    input  video_pkg::rgb_t                 rgb,
    output int                              colour_errs,
    output int                              blank_errs,
    output int                              timing_errs,
    output int                              checked     // pixels compared
);
    import video_pkg::*;
    import palette_pkg::*;

    logic [7:0] bak_tab   [2**bak_aw];
    logic [7:0] txt_tab   [2**bak_aw];
    logic [3:0] objlo_tab [2**obj_aw];
    logic [3:0] objhi_tab [2**obj_aw];

    int   dl_addr;
    int   hc;           // model pixel count in the line
    int   vc;           // model line count
    int   clk_gap;      // clocks since the last pixel enable
    logic seen_cen;
    logic hb_exp;
    logic vb_exp;
    rgb_t exp_d1;
    rgb_t exp_d2;
    logic vld_d1;
    logic vld_d2;

    assign dl_addr = int'(prog_addr);
    assign hb_exp  = hc < h_visible;
    assign vb_exp  = vc < v_visible;

    // which table a download address belongs to
    function automatic prom_rgn_e region_of(input int a);
        if (a >= rgn_bak_base && a < rgn_bak_base + 2**bak_aw) return rgn_bak;
        if (a >= rgn_txt_base && a < rgn_txt_base + 2**bak_aw) return rgn_txt;
        if (a >= rgn_objlo_base && a < rgn_objlo_base + 2**obj_aw) return rgn_objlo;
        if (a >= rgn_objhi_base && a < rgn_objhi_base + 2**obj_aw) return rgn_objhi;
        return rgn_none;
    endfunction

    // expected rgb for one sampled pixel
    function automatic rgb_t predict(input layer_pix_t p, input logic blank);
        logic [7:0] col;
        rgb_t       r;
        if (!p.txt_valid) begin
            col = txt_tab[{p.txt_code[3], p.txt_code}];    // text always wins
        end else if (p.obj_valid != 2'b00) begin
            col = {objhi_tab[{p.obj_code, p.obj_valid}], objlo_tab[{p.obj_code, p.obj_valid}]};
        end else begin
            col = bak_tab[p.bak_code];
        end
        col     = ~col;
        r.red   = col[2:0];
        r.green = col[5:3];
        r.blue  = col[7:6];
        if (blank) begin
            r = '0;     // black in blanking
        end
        return r;
    endfunction

    // shadow tables follow the download bus
    always @(posedge clk) begin
        if (prog_we) begin
            case (region_of(dl_addr))
                rgn_bak:   bak_tab[bak_aw'(dl_addr - rgn_bak_base)] <= prog_data;
                rgn_txt:   txt_tab[bak_aw'(dl_addr - rgn_txt_base)] <= prog_data;
                rgn_objlo: objlo_tab[obj_aw'(dl_addr - rgn_objlo_base)] <= prog_data[3:0];
                rgn_objhi: objhi_tab[obj_aw'(dl_addr - rgn_objhi_base)] <= prog_data[3:0];
                default: ;  // gap in the map, dropped
            endcase
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hc          <= 0;
            vc          <= 0;
            clk_gap     <= 0;
            seen_cen    <= 1'b0;
            exp_d1      <= '0;
            exp_d2      <= '0;
            vld_d1      <= 1'b0;
            vld_d2      <= 1'b0;
            colour_errs <= 0;
            blank_errs  <= 0;
            timing_errs <= 0;
            checked     <= 0;
        end else begin
            clk_gap <= pxl_cen ? 1 : clk_gap + 1;
            if (!seen_cen && rgb !== rgb_t'(8'h00)) begin
                $display("ERR %0t: rgb %h after reset, expected black", $time, rgb);
                timing_errs <= timing_errs + 1;
            end
            if (pxl_cen) begin
                seen_cen <= 1'b1;
                if (seen_cen && clk_gap != pxl_div) begin
                    $display("ERR %0t: pixel enable after %0d clocks, expected %0d",
                             $time, clk_gap, pxl_div);
                    timing_errs <= timing_errs + 1;
                end
                if (hblank_n !== hb_exp || vblank_n !== vb_exp) begin
                    $display("ERR %0t: blanking h %b v %b at %0d,%0d, expected h %b v %b",
                             $time, hblank_n, vblank_n, hc, vc, hb_exp, vb_exp);
                    blank_errs <= blank_errs + 1;
                end
                // frame position advances on every enable
                hc <= (hc == h_total - 1) ? 0 : hc + 1;
                if (hc == h_total - 1) begin
                    vc <= (vc == v_total - 1) ? 0 : vc + 1;
                end
                // rgb seen now was made at the last enable from the sample before it
                if (vld_d2) begin
                    checked <= checked + 1;
                    if (rgb !== exp_d2) begin
                        $display("ERR %0t: rgb %h, expected %h", $time, rgb, exp_d2);
                        colour_errs <= colour_errs + 1;
                    end
                end
                exp_d2 <= exp_d1;
                vld_d2 <= vld_d1;
                exp_d1 <= predict(pix, !hb_exp || !vb_exp);
                vld_d1 <= check_en;
            end
        end
    end

endmodule

// File: tb/tb_top.sv
// ==================================================
// tb_top
// testbench of the video board colour stage, loads
// random colour tables and drives random layer codes
// for two frames
// ==================================================
`timescale 1ns/1ns

module tb_top;
    import video_pkg::*;
    import palette_pkg::*;

    localparam int cen_limit = 16;  // clocks allowed while waiting for pxl_cen
    localparam int n_stray   = 64;  // out-of-region download writes

    logic               clk = 1'b0;
    logic               arst_n;
    logic [prog_aw-1:0] prog_addr;
    logic [7:0]         prog_data;
    logic               prog_we;
    layer_pix_t         pix;
    logic               pxl_cen;
    logic               hblank_n;
    logic               vblank_n;
    rgb_t               rgb;
    logic               check_en;
    logic               timed_out;
    logic [31:0]        lfsr;
    int                 colour_errs;
    int                 blank_errs;
    int                 timing_errs;
    int                 checked;
    int                 err_total;
    int                 stray_addr;

    always #4 clk = ~clk;   // 8 ns period

    video_top dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_we   (prog_we),
        .pix       (pix),
        .pxl_cen   (pxl_cen),
        .hblank_n  (hblank_n),
        .vblank_n  (vblank_n),
        .rgb       (rgb)
    );

    colmix_checker colmix_chk_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .check_en    (check_en),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_we     (prog_we),
        .pix         (pix),
        .pxl_cen     (pxl_cen),
        .hblank_n    (hblank_n),
        .vblank_n    (vblank_n),
        .rgb         (rgb),
        .colour_errs (colour_errs),
        .blank_errs  (blank_errs),
        .timing_errs (timing_errs),
        .checked     (checked)
    );

    // galois lfsr, right shifting
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // n random bits, one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // address inside any of the four tables
    function automatic logic in_map(input int a);
        return a < rgn_txt_base + 2**bak_aw ||
               (a >= rgn_objlo_base && a < rgn_objhi_base + 2**obj_aw);
    endfunction

    // one download byte, strobe high for a single clock
    task automatic prog_write(input int addr, input logic [7:0] data);
        @(posedge clk);
        prog_addr <= prog_aw'(addr);
        prog_data <= data;
        prog_we   <= 1'b1;
        @(posedge clk);
        prog_we   <= 1'b0;
    endtask

    // rising edge where pxl_cen is high, gives up after cen_limit clocks
    task automatic wait_cen();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!pxl_cen && n < cen_limit);
        if (!pxl_cen) begin
            timed_out = 1'b1;
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        prog_we   = 1'b0;
        pix       = '0;
        check_en  = 1'b0;
        timed_out = 1'b0;
        lfsr      = 32'h2481;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        // fill every table
        for (int a = 0; a < 2**bak_aw; a++) begin
            prog_write(rgn_bak_base + a, 8'(rand_bits(8)));
            prog_write(rgn_txt_base + a, 8'(rand_bits(8)));
        end
        for (int a = 0; a < 2**obj_aw; a++) begin
            prog_write(rgn_objlo_base + a, 8'(rand_bits(8)));  // high nibble ignored
            prog_write(rgn_objhi_base + a, 8'(rand_bits(8)));
        end
        // stray writes last, so a wrong decode would overwrite live entries
        for (int i = 0; i < n_stray; i++) begin
            stray_addr = int'(rand_bits(prog_aw));
            for (int t = 0; t < 64 && in_map(stray_addr); t++) begin
                stray_addr = int'(rand_bits(prog_aw));
            end
            if (!in_map(stray_addr)) begin
                prog_write(stray_addr, 8'(rand_bits(8)));
            end
        end
        repeat (4) @(posedge clk);

        // two frames of random layer codes
        check_en <= 1'b1;
        for (int i = 0; i < 2 * h_total * v_total && !timed_out; i++) begin
            wait_cen();
            pix <= layer_pix_t'(18'(rand_bits(18)));  // sampled at the next enable
        end
        for (int i = 0; i < 3 && !timed_out; i++) begin
            wait_cen();     // let the last pixels reach rgb
        end
        @(posedge clk);     // last compare lands in the checker counts

        err_total = colour_errs + blank_errs + timing_errs;
        $display("errors: colour %0d, blanking %0d, timing %0d, pixels compared %0d",
                 colour_errs, blank_errs, timing_errs, checked);
        if (timed_out) begin
            $display("pixel enable did not arrive within %0d clocks, run stopped", cen_limit);
        end
        if (checked == 0) begin
            $display("no pixel was compared");
        end
        if (err_total == 0 && !timed_out && checked > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
common/video_pkg.sv
common/palette_pkg.sv
hw/video_timing.sv
hw/prom_loader.sv
hw/colmix/palette_prom.sv
hw/colmix/colmix.sv
hw/video_top.sv
tb/colmix_checker.sv
tb/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator
# the run passes only if the log holds the pass line
rm -rf obj_dir sim.log
verilator --binary --timing -f src.f --top-module tb_top -o tb_sim &&
    ./obj_dir/tb_sim > sim.log 2>&1 ||
    { cat sim.log 2>/dev/null; echo "compile or run step failed"; exit 1; }
cat sim.log
grep -qx "TESTBENCH PASSED" sim.log && echo "result: pass" ||
    { echo "result: fail"; exit 1; }
